// ==== sim.f ====
+incdir+rtl
rtl/pic_pkg.sv
rtl/pic_reg_decode.sv
rtl/pic_source_channel.sv
rtl/pic_arbiter.sv
rtl/pic_top.sv
testbench/pic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the interrupt controller testbench with Verilator and runs it.
# The exit status is non-zero when the build fails or the run reports a failure.

verilator --binary --timing --assert -f sim.f --top-module pic_tb -o pic_sim > build.log 2>&1 &&
./obj_dir/pic_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== testbench/pic_tb.sv ====
//////////////////////////////
// Testbench for the interrupt controller top level
// Drives the register port and source lines on the falling edge and
// compares the claim outputs with a reference model of the arbitration
//////////////////////////////

`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_tb;

   localparam int MAX_CYCLES = 5000;   // Whole run is about 1500 cycles

   logic               clk;
   logic               reset;
   pic_pkg::src_vec_t  extintsrc_req;
   pic_pkg::bus_addr_t addr;
   pic_pkg::bus_data_t wr_data;
   logic               wren;
   logic               rden;
   pic_pkg::prio_t     meipt;
   pic_pkg::prio_t     meicurpl;
   pic_pkg::bus_data_t rd_data;
   pic_pkg::int_id_t   claimid;
   pic_pkg::prio_t     pl;
   logic               mexintpend;
   logic               mhwakeup;

   // Shadow copy of the register state
   pic_pkg::prio_t     sh_prio [`PIC_NUM_SRC];
   logic               sh_en [`PIC_NUM_SRC];
   pic_pkg::gw_cfg_t   sh_gw [`PIC_NUM_SRC];
   logic               sh_edge [`PIC_NUM_SRC];   // Latched edge requests
   logic               sh_order;

   logic [31:0]        lfsr_state;
   logic [9:0]         exp_q;                     // {claimid, pl, mexintpend, mhwakeup}
   event               check_ev;
   int                 pass_cnt;
   int                 fail_cnt;
   int                 cycle_cnt;

   pic_top pic_top_inst (
      .clk           (clk),
      .reset         (reset),
      .extintsrc_req (extintsrc_req),
      .addr          (addr),
      .wr_data       (wr_data),
      .wren          (wren),
      .rden          (rden),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .rd_data       (rd_data),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

   always #5 clk = ~clk;

   //////////////////////////////
   // Random numbers and reference model
   //////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic pic_pkg::src_vec_t pending_ref(input pic_pkg::src_vec_t src);
      pic_pkg::src_vec_t p;
      logic              act;
      p = '0;
      for (int i = 1; i < `PIC_NUM_SRC; i++) begin   // Slot 0 never pends
         act  = src[i] ^ sh_gw[i][0];
         p[i] = sh_gw[i][1] ? (act | sh_edge[i]) : act;
      end
      return p;
   endfunction

   function automatic logic [9:0] expect_outputs(input pic_pkg::src_vec_t src,
                                                 input pic_pkg::prio_t thr,
                                                 input pic_pkg::prio_t cur);
      pic_pkg::src_vec_t p;
      pic_pkg::prio_t    eff;
      pic_pkg::prio_t    best;
      pic_pkg::prio_t    pl_e;
      pic_pkg::int_id_t  id;
      logic              req;
      logic              wake;
      p    = pending_ref(src);
      best = '0;
      id   = '0;
      for (int i = 1; i < `PIC_NUM_SRC; i++) begin
         eff = (p[i] && sh_en[i]) ? (sh_order ? ~sh_prio[i] : sh_prio[i]) : '0;
         if (eff > best) begin   // Strictly greater keeps the lower id on ties
            best = eff;
            id   = pic_pkg::int_id_t'(i);
         end
      end
      pl_e = sh_order ? ~best : best;
      wake = (pl_e == (sh_order ? 4'h0 : 4'hF));
      req  = (best > (sh_order ? ~thr : thr)) && (best > (sh_order ? ~cur : cur));
      return {id, pl_e, req, wake};
   endfunction

   function automatic pic_pkg::bus_addr_t reg_addr(input pic_pkg::bus_addr_t ofs, input int id);
      return `PIC_BASE_ADDR + ofs + pic_pkg::bus_addr_t'(4 * id);
   endfunction

   //////////////////////////////
   // Bus tasks
   //////////////////////////////
   task automatic bus_write(input pic_pkg::bus_addr_t a, input pic_pkg::bus_data_t d);
      addr    = a;
      wr_data = d;
      wren    = 1'b1;
      @(negedge clk);
      wren = 1'b0;
   endtask

   task automatic read_check(input pic_pkg::bus_addr_t a, input pic_pkg::bus_data_t exp_d);
      pic_pkg::bus_data_t got;
      addr = a;
      rden = 1'b1;
      @(negedge clk);   // Data valid in the cycle after the sampling edge
      got  = rd_data;
      rden = 1'b0;
      assert (got == exp_d)
         pass_cnt++;
      else begin
         $display("[FAIL] %0t: read at 0x%08h gave 0x%08h, expected 0x%08h",
                  $time, a, got, exp_d);
         fail_cnt++;
      end
   endtask

   task automatic set_prio(input int id, input pic_pkg::bus_data_t d);
      bus_write(reg_addr(`PIC_PRIO_OFS, id), d);
      sh_prio[id] = d[3:0];
   endtask

   task automatic set_enable(input int id, input pic_pkg::bus_data_t d);
      bus_write(reg_addr(`PIC_ENABLE_OFS, id), d);
      sh_en[id] = d[0];
   endtask

   task automatic set_gw(input int id, input pic_pkg::bus_data_t d);
      bus_write(reg_addr(`PIC_GW_CONFIG_OFS, id), d);
      sh_gw[id]   = d[1:0];
      sh_edge[id] = 1'b0;   // Leaving edge mode drops the latch
   endtask

   task automatic set_order(input pic_pkg::bus_data_t d);
      bus_write(reg_addr(`PIC_CONFIG_OFS, 0), d);
      sh_order = d[0];
   endtask

   // Wait for the outputs to settle, then hand the expected values over
   task automatic settle_and_check(input int settle);
      repeat (settle) @(negedge clk);
      exp_q = expect_outputs(extintsrc_req, meipt, meicurpl);
      -> check_ev;
      @(negedge clk);
   endtask

   task automatic report_test(input string name, input int fails_before);
      $display("Test %s finished with %0d failed checks", name, fail_cnt - fails_before);
   endtask

   //////////////////////////////
   // Comparing process and timeout
   //////////////////////////////
   always @(check_ev) begin
      assert ({claimid, pl, mexintpend, mhwakeup} == exp_q)
         pass_cnt++;
      else begin
         $display("[FAIL] %0t: id %0d pl %0d ext %0b wake %0b, expected %0d %0d %0b %0b",
                  $time, claimid, pl, mexintpend, mhwakeup,
                  exp_q[9:6], exp_q[5:2], exp_q[1], exp_q[0]);
         fail_cnt++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles, the tests did not finish in time", MAX_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial begin
      logic [31:0] rnd;
      int          fails_before;
      clk = 1'b0;
      reset = 1'b1;
      extintsrc_req = '0;
      addr = '0;
      wr_data = '0;
      wren = 1'b0;
      rden = 1'b0;
      meipt = '0;
      meicurpl = '0;
      lfsr_state = 32'h4f95_d302;
      pass_cnt = 0;
      fail_cnt = 0;
      cycle_cnt = 0;
      sh_order = 1'b0;
      for (int i = 0; i < `PIC_NUM_SRC; i++) begin
         sh_prio[i] = '0;
         sh_en[i]   = 1'b0;
         sh_gw[i]   = '0;
         sh_edge[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Register readback with writes to slot 0 ignored
      fails_before = fail_cnt;
      for (int i = 1; i < `PIC_NUM_SRC; i++) begin
         set_prio(i, rand_bits(32));
         set_enable(i, rand_bits(32));
         set_gw(i, rand_bits(32));
      end
      set_order(rand_bits(32));
      bus_write(reg_addr(`PIC_PRIO_OFS, 0), 32'hFFFF_FFFF);
      bus_write(reg_addr(`PIC_ENABLE_OFS, 0), 32'hFFFF_FFFF);
      bus_write(reg_addr(`PIC_GW_CONFIG_OFS, 0), 32'hFFFF_FFFF);
      for (int i = 0; i < `PIC_NUM_SRC; i++) begin
         read_check(reg_addr(`PIC_PRIO_OFS, i), pic_pkg::bus_data_t'(sh_prio[i]));
         read_check(reg_addr(`PIC_ENABLE_OFS, i), pic_pkg::bus_data_t'(sh_en[i]));
         read_check(reg_addr(`PIC_GW_CONFIG_OFS, i), pic_pkg::bus_data_t'(sh_gw[i]));
      end
      read_check(reg_addr(`PIC_CONFIG_OFS, 0), pic_pkg::bus_data_t'(sh_order));
      report_test("1 register readback", fails_before);

      // Level arbitration with random sources
      fails_before = fail_cnt;
      set_order(32'h0);
      for (int i = 1; i < `PIC_NUM_SRC; i++) begin
         set_gw(i, 32'h0);
         set_prio(i, rand_bits(4));
         set_enable(i, rand_bits(1));
      end
      for (int n = 0; n < 24; n++) begin
         rnd = rand_bits(16);
         extintsrc_req = rnd[15:0];
         rnd = rand_bits(4);
         if (rnd[3:0] != 4'h0) begin
            set_prio(int'(rnd[3:0]), rand_bits(4));
            set_enable(int'(rnd[3:0]), rand_bits(1));
         end
         settle_and_check(4);
      end
      report_test("2 level arbitration", fails_before);

      // Threshold sweep against one known winner
      fails_before = fail_cnt;
      extintsrc_req = 16'h0020;            // Only source 5 active
      set_prio(5, 32'h9);
      set_enable(5, 32'h1);
      settle_and_check(4);
      for (int t = 0; t < 16; t++) begin
         for (int c = 0; c < 16; c++) begin
            meipt    = pic_pkg::prio_t'(t);
            meicurpl = pic_pkg::prio_t'(c);
            settle_and_check(2);
         end
      end
      report_test("3 threshold gating", fails_before);

      // Edge gateway with inverted polarity so the line idles high
      fails_before = fail_cnt;
      meipt = '0;
      meicurpl = '0;
      extintsrc_req = 16'h0008;
      repeat (4) @(negedge clk);
      set_gw(3, 32'h3);
      set_prio(3, 32'h6);
      set_enable(3, 32'h1);
      settle_and_check(4);
      read_check(reg_addr(`PIC_PEND_OFS, 0), pic_pkg::bus_data_t'(pending_ref(extintsrc_req)));
      extintsrc_req[3] = 1'b0;             // One cycle pulse
      @(negedge clk);
      extintsrc_req[3] = 1'b1;
      sh_edge[3] = 1'b1;
      settle_and_check(4);
      read_check(reg_addr(`PIC_PEND_OFS, 0), pic_pkg::bus_data_t'(pending_ref(extintsrc_req)));
      bus_write(reg_addr(`PIC_GW_CLEAR_OFS, 3), 32'h0);
      sh_edge[3] = 1'b0;
      settle_and_check(4);
      read_check(reg_addr(`PIC_PEND_OFS, 0), pic_pkg::bus_data_t'(pending_ref(extintsrc_req)));
      report_test("4 edge gateway", fails_before);

      // Reverse order where level 0 is the most urgent and wakes the core
      fails_before = fail_cnt;
      set_order(32'h1);
      set_gw(7, 32'h0);
      set_prio(7, 32'h0);
      set_enable(7, 32'h1);
      extintsrc_req = 16'h00A8;            // Sources 5 and 7 active, 3 idle
      meicurpl = 4'hF;
      for (int t = 0; t < 16; t++) begin
         meipt = pic_pkg::prio_t'(t);
         settle_and_check((t == 0) ? 4 : 2);
      end
      set_enable(7, 32'h0);
      settle_and_check(4);
      report_test("5 reverse order and wake-up", fails_before);

      $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== rtl/pic_top.sv ====
//////////////////////////////
// Interrupt controller top level
// Register decoder, one channel per source 1 to 15, and the arbiter
//////////////////////////////

`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_top (
   input  logic               clk,
   input  logic               reset,
   input  pic_pkg::src_vec_t  extintsrc_req,
   input  pic_pkg::bus_addr_t addr,
   input  pic_pkg::bus_data_t wr_data,
   input  logic               wren,
   input  logic               rden,
   input  pic_pkg::prio_t     meipt,
   input  pic_pkg::prio_t     meicurpl,
   output pic_pkg::bus_data_t rd_data,
   output pic_pkg::int_id_t   claimid,
   output pic_pkg::prio_t     pl,
   output logic               mexintpend,
   output logic               mhwakeup
);

   pic_pkg::src_vec_t  prio_we;
   pic_pkg::src_vec_t  enable_we;
   pic_pkg::src_vec_t  gw_cfg_we;
   pic_pkg::src_vec_t  gw_clr;
   pic_pkg::bus_data_t wr_data_q;
   logic               order_rev;
   pic_pkg::prio_t     prio_q [`PIC_NUM_SRC];
   pic_pkg::src_vec_t  enable_q;
   pic_pkg::gw_cfg_t   gw_cfg_q [`PIC_NUM_SRC];
   pic_pkg::src_vec_t  pending;
   pic_pkg::prio_t     eff_prio [`PIC_NUM_SRC];

   pic_reg_decode pic_reg_decode_inst (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .wr_data   (wr_data),
      .wren      (wren),
      .rden      (rden),
      .prio_q    (prio_q),
      .enable_q  (enable_q),
      .gw_cfg_q  (gw_cfg_q),
      .pending   (pending),
      .prio_we   (prio_we),
      .enable_we (enable_we),
      .gw_cfg_we (gw_cfg_we),
      .gw_clr    (gw_clr),
      .wr_data_q (wr_data_q),
      .order_rev (order_rev),
      .rd_data   (rd_data)
   );

   // Reserved slot 0
   assign prio_q[0]   = '0;
   assign enable_q[0] = 1'b0;
   assign gw_cfg_q[0] = '0;
   assign pending[0]  = 1'b0;
   assign eff_prio[0] = '0;

   for (genvar i = 1; i < `PIC_NUM_SRC; i++) begin : src_gen
      pic_source_channel channel_inst (
         .clk       (clk),
         .reset     (reset),
         .src_req   (extintsrc_req[i]),
         .prio_we   (prio_we[i]),
         .enable_we (enable_we[i]),
         .gw_cfg_we (gw_cfg_we[i]),
         .gw_clr    (gw_clr[i]),
         .wr_data_q (wr_data_q),
         .order_rev (order_rev),
         .prio_q    (prio_q[i]),
         .enable_q  (enable_q[i]),
         .gw_cfg_q  (gw_cfg_q[i]),
         .pending   (pending[i]),
         .eff_prio  (eff_prio[i])
      );
   end

   pic_arbiter pic_arbiter_inst (
      .clk        (clk),
      .reset      (reset),
      .eff_prio   (eff_prio),
      .order_rev  (order_rev),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

// ==== rtl/pic_arbiter.sv ====
//////////////////////////////
// Picks the most urgent pending source and gates it by threshold
// Ties go to the lower id, all outputs are registered
//////////////////////////////

`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_arbiter (
   input  logic             clk,
   input  logic             reset,
   input  pic_pkg::prio_t   eff_prio [`PIC_NUM_SRC],
   input  logic             order_rev,
   input  pic_pkg::prio_t   meipt,
   input  pic_pkg::prio_t   meicurpl,
   output pic_pkg::int_id_t claimid,
   output pic_pkg::prio_t   pl,
   output logic             mexintpend,
   output logic             mhwakeup
);

   localparam int LEVELS = $clog2(`PIC_NUM_SRC);

   pic_pkg::prio_t   win_prio;
   pic_pkg::int_id_t win_id;
   pic_pkg::prio_t   meipt_ord;
   pic_pkg::prio_t   meicurpl_ord;
   pic_pkg::prio_t   pl_d;
   pic_pkg::prio_t   max_level;
   logic             mexintpend_d;
   logic             mhwakeup_d;

   //////////////////////////////
   // Comparison tree
   //////////////////////////////
   // Each level folds pairs into the left node, right wins only when larger
   always_comb begin : cmp_tree
      pic_pkg::prio_t   node_prio [`PIC_NUM_SRC];
      pic_pkg::int_id_t node_id [`PIC_NUM_SRC];
      for (int i = 0; i < `PIC_NUM_SRC; i++) begin
         node_prio[i] = eff_prio[i];
         node_id[i]   = pic_pkg::int_id_t'(i);
      end
      for (int l = 0; l < LEVELS; l++) begin
         for (int i = 0; i < `PIC_NUM_SRC; i += (2 << l)) begin
            if (node_prio[i + (1 << l)] > node_prio[i]) begin
               node_prio[i] = node_prio[i + (1 << l)];
               node_id[i]   = node_id[i + (1 << l)];
            end
         end
      end
      win_prio = node_prio[0];
      win_id   = node_id[0];
   end

   //////////////////////////////
   // Threshold and wake-up
   //////////////////////////////
   assign meipt_ord    = order_rev ? ~meipt : meipt;         // Same scale as the tree
   assign meicurpl_ord = order_rev ? ~meicurpl : meicurpl;

   assign mexintpend_d = (win_prio > meipt_ord) & (win_prio > meicurpl_ord);

   assign pl_d      = order_rev ? ~win_prio : win_prio;      // Back to register encoding
   assign max_level = order_rev ? '0 : '1;
   assign mhwakeup_d = (pl_d == max_level);

   always_ff @(posedge clk) begin
      if (reset) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= win_id;
         pl         <= pl_d;
         mexintpend <= mexintpend_d;
         mhwakeup   <= mhwakeup_d;
      end
   end

   // Holds only while slot 0 stays tied off at the top
   a_req_has_id : assert property (@(posedge clk) disable iff (reset)
      mexintpend |-> (claimid != '0));

endmodule

// ==== rtl/pic_source_channel.sv ====
//////////////////////////////
// One interrupt source slot
// Input synchronizer, gateway, priority and enable registers
// eff_prio feeds the arbiter tree and is zero when not requesting
//////////////////////////////

`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_source_channel (
   input  logic               clk,
   input  logic               reset,
   input  logic               src_req,
   input  logic               prio_we,
   input  logic               enable_we,
   input  logic               gw_cfg_we,
   input  logic               gw_clr,
   input  pic_pkg::bus_data_t wr_data_q,
   input  logic               order_rev,
   output pic_pkg::prio_t     prio_q,
   output logic               enable_q,
   output pic_pkg::gw_cfg_t   gw_cfg_q,
   output logic               pending,
   output pic_pkg::prio_t     eff_prio
);

   logic           sync_meta;   // First synchronizer stage
   logic           sync_req;
   logic           req_act;     // Input after polarity
   logic           edge_pend;
   pic_pkg::prio_t prio_ord;

   always_ff @(posedge clk) begin
      if (reset) begin
         sync_meta <= 1'b0;
         sync_req  <= 1'b0;
      end else begin
         sync_meta <= src_req;
         sync_req  <= sync_meta;
      end
   end

   //////////////////////////////
   // Configuration registers
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         prio_q   <= '0;
         enable_q <= 1'b0;
         gw_cfg_q <= '0;
      end else begin
         if (prio_we)   prio_q   <= wr_data_q[`PIC_PRIO_BITS-1:0];
         if (enable_we) enable_q <= wr_data_q[0];
         if (gw_cfg_we) gw_cfg_q <= wr_data_q[$bits(pic_pkg::gw_cfg_t)-1:0];
      end
   end

   // Gateway
   assign req_act = sync_req ^ gw_cfg_q[0];

   always_ff @(posedge clk) begin
      if (reset) edge_pend <= 1'b0;
      else edge_pend <= gw_cfg_q[1] & (req_act | (edge_pend & ~gw_clr));   // Sticky in edge mode
   end

   assign pending = gw_cfg_q[1] ? (req_act | edge_pend) : req_act;

   assign prio_ord = order_rev ? ~prio_q : prio_q;   // Larger is always more urgent
   assign eff_prio = (pending & enable_q) ? prio_ord : '0;

endmodule

// ==== rtl/pic_reg_decode.sv ====
//////////////////////////////
// Register port of the interrupt controller
// Samples the bus strobes, turns addresses into per-source write strobes,
// holds the order bit and muxes register state onto rd_data
//////////////////////////////

`timescale 1ns/1ps
`include "pic_defs.svh"

module pic_reg_decode (
   input  logic               clk,
   input  logic               reset,
   input  pic_pkg::bus_addr_t addr,
   input  pic_pkg::bus_data_t wr_data,
   input  logic               wren,
   input  logic               rden,
   input  pic_pkg::prio_t     prio_q [`PIC_NUM_SRC],
   input  pic_pkg::src_vec_t  enable_q,
   input  pic_pkg::gw_cfg_t   gw_cfg_q [`PIC_NUM_SRC],
   input  pic_pkg::src_vec_t  pending,
   output pic_pkg::src_vec_t  prio_we,
   output pic_pkg::src_vec_t  enable_we,
   output pic_pkg::src_vec_t  gw_cfg_we,
   output pic_pkg::src_vec_t  gw_clr,
   output pic_pkg::bus_data_t wr_data_q,
   output logic               order_rev,
   output pic_pkg::bus_data_t rd_data
);

   localparam int SEL_LSB = `PIC_ID_BITS + 2;   // Lowest block select bit

   localparam pic_pkg::bus_addr_t PRIO_BASE   = `PIC_BASE_ADDR + `PIC_PRIO_OFS;
   localparam pic_pkg::bus_addr_t PEND_BASE   = `PIC_BASE_ADDR + `PIC_PEND_OFS;
   localparam pic_pkg::bus_addr_t ENABLE_BASE = `PIC_BASE_ADDR + `PIC_ENABLE_OFS;
   localparam pic_pkg::bus_addr_t CONFIG_ADDR = `PIC_BASE_ADDR + `PIC_CONFIG_OFS;
   localparam pic_pkg::bus_addr_t GW_CFG_BASE = `PIC_BASE_ADDR + `PIC_GW_CONFIG_OFS;
   localparam pic_pkg::bus_addr_t GW_CLR_BASE = `PIC_BASE_ADDR + `PIC_GW_CLEAR_OFS;

   logic               wren_q;
   logic               rden_q;
   pic_pkg::bus_addr_t addr_q;
   pic_pkg::int_id_t   src_idx;
   logic               prio_hit;
   logic               pend_hit;
   logic               enable_hit;
   logic               config_hit;
   logic               gw_cfg_hit;
   logic               gw_clr_hit;
   pic_pkg::prio_t     prio_rd;
   logic               enable_rd;
   pic_pkg::gw_cfg_t   gw_cfg_rd;

   //////////////////////////////
   // Bus sampling
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= wren;
         rden_q <= rden;
      end
   end

   always_ff @(posedge clk) begin
      if (wren | rden) addr_q <= addr;   // Held between accesses
      if (wren) wr_data_q <= wr_data;
   end

   //////////////////////////////
   // Address decode
   //////////////////////////////
   assign src_idx    = addr_q[SEL_LSB-1:2];
   assign prio_hit   = (addr_q[31:SEL_LSB] == PRIO_BASE[31:SEL_LSB]);
   assign enable_hit = (addr_q[31:SEL_LSB] == ENABLE_BASE[31:SEL_LSB]);
   assign gw_cfg_hit = (addr_q[31:SEL_LSB] == GW_CFG_BASE[31:SEL_LSB]);
   assign gw_clr_hit = (addr_q[31:SEL_LSB] == GW_CLR_BASE[31:SEL_LSB]);
   assign pend_hit   = (addr_q == PEND_BASE);     // All 16 bits fit in one word
   assign config_hit = (addr_q == CONFIG_ADDR);

   // Slot 0 never gets a strobe and always reads back zero
   always_comb begin
      prio_we   = '0;
      enable_we = '0;
      gw_cfg_we = '0;
      gw_clr    = '0;
      prio_rd   = '0;
      enable_rd = 1'b0;
      gw_cfg_rd = '0;
      for (int i = 1; i < `PIC_NUM_SRC; i++) begin
         if (src_idx == pic_pkg::int_id_t'(i)) begin
            prio_we[i]   = wren_q & prio_hit;
            enable_we[i] = wren_q & enable_hit;
            gw_cfg_we[i] = wren_q & gw_cfg_hit;
            gw_clr[i]    = wren_q & gw_clr_hit;
            prio_rd      = prio_q[i];
            enable_rd    = enable_q[i];
            gw_cfg_rd    = gw_cfg_q[i];
         end
      end
   end

   // Global priority order, set means level 0 is the most urgent
   always_ff @(posedge clk) begin
      if (reset) order_rev <= 1'b0;
      else if (wren_q & config_hit) order_rev <= wr_data_q[0];
   end

   //////////////////////////////
   // Read data
   //////////////////////////////
   assign rd_data = ({32{rden_q & prio_hit}}   & pic_pkg::bus_data_t'(prio_rd))   |
                    ({32{rden_q & enable_hit}} & pic_pkg::bus_data_t'(enable_rd)) |
                    ({32{rden_q & gw_cfg_hit}} & pic_pkg::bus_data_t'(gw_cfg_rd)) |
                    ({32{rden_q & pend_hit}}   & pic_pkg::bus_data_t'(pending))   |
                    ({32{rden_q & config_hit}} & pic_pkg::bus_data_t'(order_rev));

   // One access per cycle on the register port
   a_no_rd_wr_overlap : assert property (@(posedge clk) disable iff (reset)
      !(wren && rden));

endmodule

// ==== rtl/pic_pkg.sv ====
//////////////////////////////
// Shared vector types of the interrupt controller
// Referenced as pic_pkg::name from RTL and testbench
//////////////////////////////

`include "pic_defs.svh"

package pic_pkg;

   // Register port
   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;

   // Interrupt side
   typedef logic [`PIC_PRIO_BITS-1:0] prio_t;     // Priority level
   typedef logic [`PIC_ID_BITS-1:0]   int_id_t;   // Source id
   typedef logic [`PIC_NUM_SRC-1:0]   src_vec_t;  // One bit per source slot

   // Gateway configuration
   // Bit 0 inverts the input, bit 1 selects edge mode
   typedef logic [1:0] gw_cfg_t;

endpackage

// ==== rtl/pic_defs.svh ====
//////////////////////////////
// Sizing and address map of the interrupt controller
// Include wherever source count, widths or offsets are needed
// Per-source registers sit at block offset plus 4 * id
//////////////////////////////

`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

// Source slots, slot 0 is reserved and never active
`define PIC_NUM_SRC       16
`define PIC_PRIO_BITS     4           // Priority level width
`define PIC_ID_BITS       4           // Claim id width

// Register block location
`define PIC_BASE_ADDR     32'hF00C_0000
`define PIC_PRIO_OFS      32'h0000_0000   // Priority per source
`define PIC_PEND_OFS      32'h0000_1000   // Pending vector, read only
`define PIC_ENABLE_OFS    32'h0000_2000   // Enable per source
`define PIC_CONFIG_OFS    32'h0000_3000   // Global order bit
`define PIC_GW_CONFIG_OFS 32'h0000_4000   // Gateway polarity and type
`define PIC_GW_CLEAR_OFS  32'h0000_5000   // Gateway clear, write only

`endif
